//--- design/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

    localparam int num_pins = 8;

    // only bits 31 to 8 take part in the compare.
    localparam logic [31:0] base_adr = 32'h2100_0000;

    // register byte offsets.
    localparam logic [7:0] off_data     = 8'h00;
    localparam logic [7:0] off_ena      = 8'h04;
    localparam logic [7:0] off_pu       = 8'h08;
    localparam logic [7:0] off_pd       = 8'h0c;
    localparam logic [7:0] off_irq_en   = 8'h10;
    localparam logic [7:0] off_irq_stat = 8'h14;

    // outputs come up disabled.
    localparam logic [num_pins-1:0] reset_oeb  = {num_pins{1'b1}};
    localparam logic [num_pins-1:0] reset_zero = {num_pins{1'b0}};

    // one register access, adapter to register block.
    typedef struct packed {
        logic [7:0]  offset;
        logic        we;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } gpio_req_t;

    // pad control bundle.
    typedef struct packed {
        logic [num_pins-1:0] out;
        logic [num_pins-1:0] oeb;
        logic [num_pins-1:0] pu;
        logic [num_pins-1:0] pd;
    } pad_ctrl_t;

endpackage

`default_nettype wire

//--- design/gpio_wb_adapter.sv
`default_nettype none

module gpio_wb_adapter (
    input  logic                clk,
    input  logic                resetn,

    input  logic [31:0]         wb_adr_i,
    input  logic [31:0]         wb_dat_i,
    input  logic [3:0]          wb_sel_i,
    input  logic                wb_we_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    output logic                wb_ack_o,
    output logic [31:0]         wb_dat_o,

    output logic                req_valid_o,
    output gpio_pkg::gpio_req_t req_o,
    input  logic                rsp_ready_i,
    input  logic [31:0]         rsp_rdata_i
);

    import gpio_pkg::*;

    logic cyc_valid;
    logic adr_hit;
    logic miss_ack_q;

    // a held strobe is not sampled again while ack is up.
    assign cyc_valid = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign adr_hit   = (wb_adr_i[31:8] == base_adr[31:8]);

    assign req_valid_o  = cyc_valid && adr_hit;
    assign req_o.offset = wb_adr_i[7:0];
    assign req_o.we     = wb_we_i;
    assign req_o.wstrb  = wb_sel_i & {4{wb_we_i}};
    assign req_o.wdata  = wb_dat_i;

    // misses are answered here with zero data.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            miss_ack_q <= 1'b0;
        end else begin
            miss_ack_q <= cyc_valid && !adr_hit;
        end
    end

    assign wb_ack_o = rsp_ready_i || miss_ack_q;
    assign wb_dat_o = rsp_ready_i ? rsp_rdata_i : 32'h0;

endmodule

`default_nettype wire

//--- design/gpio_regs.sv
`default_nettype none

module gpio_regs (
    input  logic                               clk,
    input  logic                               resetn,

    input  logic                               req_valid_i,
    input  gpio_pkg::gpio_req_t                req_i,
    output logic                               rsp_ready_o,
    output logic [31:0]                        rsp_rdata_o,

    input  logic [gpio_pkg::num_pins-1:0]      pin_in_i,
    input  logic [gpio_pkg::num_pins-1:0]      pin_rise_i,
    output gpio_pkg::pad_ctrl_t                pad_ctrl_o,
    output logic [gpio_pkg::num_pins-1:0]      irq_en_o,
    output logic                               irq_o
);

    import gpio_pkg::*;

    localparam int pad_w = 32 - num_pins;
    localparam int half_w = 16 - num_pins;

    logic                wr_en;
    logic                sel_data;
    logic                sel_ena;
    logic                sel_pu;
    logic                sel_pd;
    logic                sel_irq_en;
    logic                sel_irq_stat;
    logic [num_pins-1:0] wr_byte;
    logic [num_pins-1:0] irq_stat_q;
    logic [num_pins-1:0] stat_clr;
    logic [num_pins-1:0] stat_next;
    logic [31:0]         rdata_next;

    // byte lane 0 carries every register.
    assign wr_en   = req_valid_i && req_i.we && req_i.wstrb[0];
    assign wr_byte = req_i.wdata[num_pins-1:0];

    assign sel_data     = (req_i.offset == off_data);
    assign sel_ena      = (req_i.offset == off_ena);
    assign sel_pu       = (req_i.offset == off_pu);
    assign sel_pd       = (req_i.offset == off_pd);
    assign sel_irq_en   = (req_i.offset == off_irq_en);
    assign sel_irq_stat = (req_i.offset == off_irq_stat);

    always_comb begin
        rdata_next = 32'h0;
        if (sel_data) begin
            rdata_next = {{half_w{1'b0}}, pad_ctrl_o.out, {half_w{1'b0}}, pin_in_i};
        end else if (sel_ena) begin
            rdata_next = {{pad_w{1'b0}}, pad_ctrl_o.oeb};
        end else if (sel_pu) begin
            rdata_next = {{pad_w{1'b0}}, pad_ctrl_o.pu};
        end else if (sel_pd) begin
            rdata_next = {{pad_w{1'b0}}, pad_ctrl_o.pd};
        end else if (sel_irq_en) begin
            rdata_next = {{pad_w{1'b0}}, irq_en_o};
        end else if (sel_irq_stat) begin
            rdata_next = {{pad_w{1'b0}}, irq_stat_q};
        end
    end

    // write one to clear, a new edge wins.
    assign stat_clr  = (wr_en && sel_irq_stat) ? wr_byte : reset_zero;
    assign stat_next = (irq_stat_q & ~stat_clr) | pin_rise_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pad_ctrl_o.out <= reset_zero;
            pad_ctrl_o.oeb <= reset_oeb;
            pad_ctrl_o.pu  <= reset_zero;
            pad_ctrl_o.pd  <= reset_zero;
            irq_en_o       <= reset_zero;
            irq_stat_q     <= reset_zero;
            irq_o          <= 1'b0;
            rsp_ready_o    <= 1'b0;
        end else begin
            rsp_ready_o <= req_valid_i;
            irq_stat_q  <= stat_next;
            irq_o       <= |stat_next;
            if (wr_en) begin
                if (sel_data) begin
                    pad_ctrl_o.out <= wr_byte;
                end
                if (sel_ena) begin
                    pad_ctrl_o.oeb <= wr_byte;
                end
                if (sel_pu) begin
                    pad_ctrl_o.pu <= wr_byte;
                end
                if (sel_pd) begin
                    pad_ctrl_o.pd <= wr_byte;
                end
                if (sel_irq_en) begin
                    irq_en_o <= wr_byte;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rsp_rdata_o <= rdata_next;
        end
    end

endmodule

`default_nettype wire

//--- design/gpio_pads.sv
`default_nettype none

module gpio_pads (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [gpio_pkg::num_pins-1:0] gpio_in_i,
    input  gpio_pkg::pad_ctrl_t           pad_ctrl_i,
    input  logic [gpio_pkg::num_pins-1:0] irq_en_i,

    output logic [gpio_pkg::num_pins-1:0] pin_in_o,
    output logic [gpio_pkg::num_pins-1:0] pin_rise_o,
    output gpio_pkg::pad_ctrl_t           pad_ctrl_o
);

    import gpio_pkg::*;

    logic [num_pins-1:0] sync_q1;
    logic [num_pins-1:0] sync_q2;
    logic [num_pins-1:0] hist_q;

    // two flops against metastability, then edge history.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sync_q1 <= reset_zero;
            sync_q2 <= reset_zero;
            hist_q  <= reset_zero;
        end else begin
            sync_q1 <= gpio_in_i;
            sync_q2 <= sync_q1;
            hist_q  <= sync_q2;
        end
    end

    assign pin_in_o = sync_q2;

    // disabled pins never report an edge.
    assign pin_rise_o = sync_q2 & ~hist_q & irq_en_i;

    // one flop stage before the pads.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pad_ctrl_o.out <= reset_zero;
            pad_ctrl_o.oeb <= reset_oeb;
            pad_ctrl_o.pu  <= reset_zero;
            pad_ctrl_o.pd  <= reset_zero;
        end else begin
            pad_ctrl_o <= pad_ctrl_i;
        end
    end

endmodule

`default_nettype wire

//--- design/gpio_top.sv
`default_nettype none

module gpio_top (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [31:0]                   wb_adr_i,
    input  logic [31:0]                   wb_dat_i,
    input  logic [3:0]                    wb_sel_i,
    input  logic                          wb_we_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    output logic                          wb_ack_o,
    output logic [31:0]                   wb_dat_o,

    input  logic [gpio_pkg::num_pins-1:0] gpio_in_i,
    output gpio_pkg::pad_ctrl_t           pad_ctrl_o,
    output logic                          irq_o
);

    import gpio_pkg::*;

    logic                req_valid;
    gpio_req_t           req;
    logic                rsp_ready;
    logic [31:0]         rsp_rdata;
    pad_ctrl_t           reg_pad_ctrl;
    logic [num_pins-1:0] irq_en;
    logic [num_pins-1:0] pin_in;
    logic [num_pins-1:0] pin_rise;

    gpio_wb_adapter gpio_wb_adapter_inst (
        .clk         (clk),
        .resetn      (resetn),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .req_valid_o (req_valid),
        .req_o       (req),
        .rsp_ready_i (rsp_ready),
        .rsp_rdata_i (rsp_rdata)
    );

    gpio_regs gpio_regs_inst (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_ready_o (rsp_ready),
        .rsp_rdata_o (rsp_rdata),
        .pin_in_i    (pin_in),
        .pin_rise_i  (pin_rise),
        .pad_ctrl_o  (reg_pad_ctrl),
        .irq_en_o    (irq_en),
        .irq_o       (irq_o)
    );

    gpio_pads gpio_pads_inst (
        .clk        (clk),
        .resetn     (resetn),
        .gpio_in_i  (gpio_in_i),
        .pad_ctrl_i (reg_pad_ctrl),
        .irq_en_i   (irq_en),
        .pin_in_o   (pin_in),
        .pin_rise_o (pin_rise),
        .pad_ctrl_o (pad_ctrl_o)
    );

endmodule

`default_nettype wire

//--- testbench/gpio_tb.sv
`default_nettype none

module gpio_tb;

    import gpio_pkg::*;

    localparam int clk_period    = 8;
    // worst case of one access is the start cycle plus the ack limit.
    localparam int access_cycles = 1 + 4;
    localparam int pin_cycles    = 3 + 5;
    localparam int test_cycles   = 4
                                 + 6 * access_cycles
                                 + 32 * access_cycles
                                 + 8 * (pin_cycles + access_cycles)
                                 + pin_cycles + 6 * (pin_cycles + 4 * access_cycles)
                                 + 2 * access_cycles
                                 + 12 * access_cycles
                                 + 4 + access_cycles;
    localparam int margin_cycles = 50;

    logic                clk;
    logic                resetn;
    logic [31:0]         wb_adr;
    logic [31:0]         wb_wdata;
    logic [3:0]          wb_sel;
    logic                wb_we;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_ack;
    logic [31:0]         wb_rdata;
    logic [num_pins-1:0] gpio_in;
    pad_ctrl_t           pad_ctrl;
    logic                irq;

    // shadow registers of the reference model.
    pad_ctrl_t           m_pad;
    logic [num_pins-1:0] m_irq_en;
    logic [num_pins-1:0] m_stat;
    logic [num_pins-1:0] m_pins;

    logic                exp_read;
    logic [31:0]         exp_rdata;
    pad_ctrl_t           exp_pad;
    logic                exp_irq;
    logic [15:0]         lfsr_q;
    int                  check_cnt;
    int                  err_cnt;
    int                  test_base;

    gpio_top gpio_top_inst (
        .clk        (clk),
        .resetn     (resetn),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_wdata),
        .wb_sel_i   (wb_sel),
        .wb_we_i    (wb_we),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_ack_o   (wb_ack),
        .wb_dat_o   (wb_rdata),
        .gpio_in_i  (gpio_in),
        .pad_ctrl_o (pad_ctrl),
        .irq_o      (irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hb400 : 16'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] adr);
        logic [31:0] r;
        r = 32'h0;
        if (adr[31:8] == base_adr[31:8]) begin
            case (adr[7:0])
                off_data:     r = {8'h00, m_pad.out, 8'h00, m_pins};
                off_ena:      r = 32'(m_pad.oeb);
                off_pu:       r = 32'(m_pad.pu);
                off_pd:       r = 32'(m_pad.pd);
                off_irq_en:   r = 32'(m_irq_en);
                off_irq_stat: r = 32'(m_stat);
                default:      r = 32'h0;
            endcase
        end
        return r;
    endfunction

    task automatic model_write(input logic [31:0] adr, input logic [31:0] data,
                               input logic [3:0] sel);
        logic [num_pins-1:0] b;
        b = data[num_pins-1:0];
        if (adr[31:8] == base_adr[31:8] && sel[0]) begin
            case (adr[7:0])
                off_data:     m_pad.out = b;
                off_ena:      m_pad.oeb = b;
                off_pu:       m_pad.pu = b;
                off_pd:       m_pad.pd = b;
                off_irq_en:   m_irq_en = b;
                off_irq_stat: m_stat = m_stat & ~b;
                default:      ;
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // expectation is fixed before the cycle starts.
    task automatic start_cycle(input logic [31:0] adr, input logic [31:0] data,
                               input logic [3:0] sel, input logic we);
        @(negedge clk);
        exp_read  = !we;
        exp_rdata = model_read(adr);
        if (we) begin
            model_write(adr, data, sel);
        end
        exp_pad  = m_pad;
        exp_irq  = |m_stat;
        wb_adr   = adr;
        wb_wdata = data;
        wb_sel   = sel;
        wb_we    = we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
    endtask

    task automatic wb_access(input logic [31:0] adr, input logic [31:0] data,
                             input logic [3:0] sel, input logic we);
        int waited;
        start_cycle(adr, data, sel, we);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 4);
        check_cnt++;
        assert (wb_ack) else begin
            $display("no acknowledge within 4 cycles for access to address %h", adr);
            err_cnt++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // model follows once the synchronizer and edge history have settled.
    task automatic drive_pins(input logic [num_pins-1:0] value);
        repeat (3) @(negedge clk);
        gpio_in = value;
        repeat (5) @(negedge clk);
        m_stat = m_stat | (value & ~m_pins & m_irq_en);
        m_pins = value;
        check_value("irq_o", 32'(irq), 32'(|m_stat));
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - test_base);
        end
        test_base = err_cnt;
    endtask

    // compares every ack, and the pads two cycles after a write ack.
    initial begin
        pad_ctrl_t pad_snap;
        logic      irq_snap;
        int        pad_wait;
        pad_wait = 0;
        forever begin
            @(negedge clk);
            if (pad_wait > 0) begin
                pad_wait = pad_wait - 1;
                if (pad_wait == 0) begin
                    check_value("pad_ctrl_o", 32'(pad_ctrl), 32'(pad_snap));
                    check_value("irq_o", 32'(irq), 32'(irq_snap));
                end
            end
            if (resetn && wb_ack) begin
                if (exp_read) begin
                    check_value("wb_dat_o", wb_rdata, exp_rdata);
                end else begin
                    pad_snap = exp_pad;
                    irq_snap = exp_irq;
                    pad_wait = 2;
                end
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] sel;
        logic [31:0] adr;
        int          acks;
        resetn    = 1'b0;
        wb_adr    = 32'h0;
        wb_wdata  = 32'h0;
        wb_sel    = 4'h0;
        wb_we     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        gpio_in   = reset_zero;
        exp_read  = 1'b0;
        exp_rdata = 32'h0;
        lfsr_q    = 16'd31;
        check_cnt = 0;
        err_cnt   = 0;
        test_base = 0;
        m_pad.out = reset_zero;
        m_pad.oeb = reset_oeb;
        m_pad.pu  = reset_zero;
        m_pad.pd  = reset_zero;
        m_irq_en  = reset_zero;
        m_stat    = reset_zero;
        m_pins    = reset_zero;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        check_value("pad_ctrl_o", 32'(pad_ctrl), 32'(m_pad));
        check_value("irq_o", 32'(irq), 32'(|m_stat));
        for (int k = 0; k < 6; k++) begin
            wb_access(base_adr | 32'(k * 4), 32'h0, 4'h0, 1'b0);
        end
        end_test("reset values");

        for (int i = 0; i < 16; i++) begin
            rnd = take_bits(2);
            adr = base_adr | {28'h0, rnd[1:0], 2'b00};
            sel = take_bits(4);
            rnd = take_bits(32);
            wb_access(adr, rnd, sel[3:0], 1'b1);
            wb_access(adr, 32'h0, 4'h0, 1'b0);
        end
        end_test("register write and readback");

        for (int i = 0; i < 8; i++) begin
            rnd = take_bits(num_pins);
            drive_pins(rnd[num_pins-1:0]);
            wb_access(base_adr | 32'(off_data), 32'h0, 4'h0, 1'b0);
        end
        end_test("input readback");

        adr = base_adr | 32'(off_irq_stat);
        drive_pins(reset_zero);
        for (int i = 0; i < 6; i++) begin
            rnd = take_bits(num_pins);
            wb_access(base_adr | 32'(off_irq_en), rnd, 4'h1, 1'b1);
            rnd = take_bits(num_pins);
            drive_pins(rnd[num_pins-1:0]);
            wb_access(adr, 32'h0, 4'h0, 1'b0);
            rnd = take_bits(num_pins);
            wb_access(adr, rnd, 4'h1, 1'b1);
            wb_access(adr, 32'h0, 4'h0, 1'b0);
        end
        wb_access(adr, 32'(reset_oeb), 4'h1, 1'b1);
        wb_access(adr, 32'h0, 4'h0, 1'b0);
        end_test("interrupts");

        rnd = take_bits(32);
        wb_access((base_adr ^ 32'h0000_0100) | 32'(off_data), rnd, 4'hf, 1'b1);
        wb_access((base_adr ^ 32'h1000_0000) | 32'(off_ena), rnd, 4'hf, 1'b1);
        wb_access((base_adr ^ 32'h0000_0100) | 32'(off_data), 32'h0, 4'h0, 1'b0);
        wb_access(base_adr | 32'h18, rnd, 4'hf, 1'b1);
        wb_access(base_adr | 32'h18, 32'h0, 4'h0, 1'b0);
        wb_access(base_adr | 32'h81, 32'h0, 4'h0, 1'b0);
        for (int k = 0; k < 6; k++) begin
            wb_access(base_adr | 32'(k * 4), 32'h0, 4'h0, 1'b0);
        end
        end_test("address decode");

        // a request goes out in each cycle that has strobe up and ack low.
        rnd = take_bits(num_pins);
        start_cycle(base_adr | 32'(off_data), rnd, 4'h1, 1'b1);
        acks = 0;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            // acked, held off for one cycle, then acked as a new cycle.
            check_value("wb_ack_o", 32'(wb_ack), 32'(i != 1));
            if (wb_ack) begin
                acks++;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_value("ack count", 32'(acks), 32'd2);
        wb_access(base_adr | 32'(off_data), 32'h0, 4'h0, 1'b0);
        end_test("held strobe");

        $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/gpio_pkg.sv
design/gpio_wb_adapter.sv
design/gpio_regs.sv
design/gpio_pads.sv
design/gpio_top.sv
testbench/gpio_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gpio_tb -f files.f -o gpio_sim || exit 1

sim_out="$(./obj_dir/gpio_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
